// ==== Makefile ====
# Verilator build and run of the convolution MAC testbench

VERILATOR ?= verilator
TOP       ?= tb_conv
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/conv_params.svh ====
////////////////////
// Fixed sizes of the 3x3 convolution MAC datapath
// Included by the package and by every module that needs a size
////////////////////

`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Operand and product widths
`define CONV_DATA_W   8    // Feature and weight, signed
`define CONV_PROD_W   16   // Signed product of two operands
`define CONV_ACC_W    28   // Running window sum and result

// Window shape
`define CONV_TAPS     9    // 3x3 kernel, one beat per tap

// Multiplier pipeline depth in clock cycles
`define CONV_MULT_LAT 4

`endif

// ==== src/conv_ctrl.sv ====
////////////////////
// Window sequencer, owns the input and output handshakes
////////////////////
`timescale 1ns/10ps

module conv_ctrl import conv_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  logic       in_valid,
  input  conv_op_e   in_op,
  input  logic       out_ready,
  input  logic [3:0] tap_idx,
  input  logic       last_tap,
  input  logic       drain_done,
  output logic       in_ready,
  output logic       tap_fire,
  output logic       bias_load,
  output logic       drain_start,
  output logic       first,
  output logic       out_valid
);

  conv_state_e state, state_nxt;
  logic        in_fire;

  assign in_fire     = in_valid && in_ready;
  assign tap_fire    = in_fire && (in_op == OP_TAP);
  assign bias_load   = in_fire && (in_op == OP_BIAS) && (state == ST_IDLE);
  assign drain_start = tap_fire && last_tap;  // Ninth tap accepted
  assign first       = (tap_idx == '0);

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:  if (tap_fire)    state_nxt = ST_TAPS;
      ST_TAPS:  if (drain_start) state_nxt = ST_DRAIN;
      ST_DRAIN: if (drain_done)  state_nxt = ST_SEND;
      ST_SEND:  if (out_ready)   state_nxt = ST_IDLE;
      default:                   state_nxt = ST_IDLE;
    endcase
  end

  ////////////////////
  // Handshake outputs are registered from the next state
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= ST_IDLE;
      in_ready  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      state     <= state_nxt;
      in_ready  <= (state_nxt == ST_IDLE) || (state_nxt == ST_TAPS);
      out_valid <= (state_nxt == ST_SEND);
    end
  end

  // Bias beats belong between windows
  a_no_bias_in_taps: assert property (@(posedge clk) disable iff (!rstn)
    (state == ST_TAPS) && in_valid |-> (in_op == OP_TAP));

  // Window start in ST_IDLE only, and the tap counter agrees with the state
  a_fire_in_accept: assert property (@(posedge clk) disable iff (!rstn)
    tap_fire |-> ((state == ST_IDLE) && first) || ((state == ST_TAPS) && !first));

endmodule

// ==== src/conv_pkg.sv ====
////////////////////
// Shared types of the convolution MAC unit
////////////////////

package conv_pkg;

  `include "conv_params.svh"

  // Beat kind on the input stream
  typedef enum logic {
    OP_TAP  = 1'b0,
    OP_BIAS = 1'b1
  } conv_op_e;

  // Input beat, a bias beat carries {feat, wgt} as one 16-bit value
  typedef struct packed {
    conv_op_e                      op;
    logic signed [`CONV_DATA_W-1:0] feat;
    logic signed [`CONV_DATA_W-1:0] wgt;
  } conv_beat_t;

  // Multiplier output with the window start marker
  typedef struct packed {
    logic signed [`CONV_PROD_W-1:0] prod;
    logic                           first;
  } conv_prod_t;

  typedef enum logic [1:0] {ST_IDLE, ST_TAPS, ST_DRAIN, ST_SEND} conv_state_e;

  typedef logic signed [`CONV_ACC_W-1:0] conv_acc_t;

endpackage

// ==== src/conv_top.sv ====
////////////////////
// Streaming 3x3 convolution MAC, taps and bias in, window sums out
////////////////////
`timescale 1ns/10ps

module conv_top import conv_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  logic       in_valid,
  output logic       in_ready,
  input  conv_beat_t in_beat,
  output logic       out_valid,
  input  logic       out_ready,
  output conv_acc_t  out_sum
);

  logic       tap_fire, bias_load, drain_start, first;
  logic       last_tap, drain_done;
  logic [3:0] tap_idx;
  logic       prod_valid;
  conv_prod_t prod;

  conv_ctrl u_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .in_valid    (in_valid),
    .in_op       (in_beat.op),
    .out_ready   (out_ready),
    .tap_idx     (tap_idx),
    .last_tap    (last_tap),
    .drain_done  (drain_done),
    .in_ready    (in_ready),
    .tap_fire    (tap_fire),
    .bias_load   (bias_load),
    .drain_start (drain_start),
    .first       (first),
    .out_valid   (out_valid)
  );

  tap_counter u_cnt (
    .clk         (clk),
    .rstn        (rstn),
    .tap_fire    (tap_fire),
    .drain_start (drain_start),
    .tap_idx     (tap_idx),
    .last_tap    (last_tap),
    .drain_done  (drain_done)
  );

  sign_mag_mult u_mult (
    .clk        (clk),
    .rstn       (rstn),
    .in_fire    (tap_fire),
    .feat       (in_beat.feat),
    .wgt        (in_beat.wgt),
    .first      (first),
    .prod_valid (prod_valid),
    .prod       (prod)
  );

  // Bias beat packs feat as the upper byte
  mac_accum u_acc (
    .clk        (clk),
    .rstn       (rstn),
    .prod_valid (prod_valid),
    .prod       (prod),
    .bias_load  (bias_load),
    .bias_in    ({in_beat.feat, in_beat.wgt}),
    .sum        (out_sum)
  );

endmodule

// ==== src/mac_accum.sv ====
////////////////////
// Window accumulator with bias register
// First product of a window restarts the sum from the bias
////////////////////
`timescale 1ns/10ps
`include "conv_params.svh"

module mac_accum import conv_pkg::*; (
  input  logic                             clk,
  input  logic                             rstn,
  input  logic                             prod_valid,
  input  conv_prod_t                       prod,
  input  logic                             bias_load,
  input  logic signed [2*`CONV_DATA_W-1:0] bias_in,
  output conv_acc_t                        sum
);

  logic signed [2*`CONV_DATA_W-1:0] bias_q;
  conv_acc_t                        prod_ext, bias_ext;

  // Sign extension to accumulator width
  assign prod_ext = conv_acc_t'(prod.prod);
  assign bias_ext = conv_acc_t'(bias_q);

  // Bias survives across windows until replaced
  always_ff @(posedge clk) begin
    if (!rstn)
      bias_q <= '0;
    else if (bias_load)
      bias_q <= bias_in;
  end

  ////////////////////
  // Running sum
  always_ff @(posedge clk) begin
    if (prod_valid) begin
      if (prod.first)
        sum <= bias_ext + prod_ext;  // New window
      else
        sum <= sum + prod_ext;
    end
  end

endmodule

// ==== src/sign_mag_mult.sv ====
////////////////////
// Four-stage signed 8x8 multiplier, partial products and adder tree
// Valid and first-tap flag travel with each product
////////////////////
`timescale 1ns/10ps
`include "conv_params.svh"

module sign_mag_mult import conv_pkg::*; (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           in_fire,
  input  logic signed [`CONV_DATA_W-1:0] feat,
  input  logic signed [`CONV_DATA_W-1:0] wgt,
  input  logic                           first,
  output logic                           prod_valid,
  output conv_prod_t                     prod
);

  logic [`CONV_DATA_W-1:0]   a_mag, b_mag;
  logic [`CONV_DATA_W-1:0]   pp      [`CONV_DATA_W];
  logic [`CONV_DATA_W-1:0]   pp_q    [`CONV_DATA_W];
  logic [`CONV_DATA_W+1:0]   pair    [`CONV_DATA_W/2];
  logic [`CONV_DATA_W+1:0]   pair_q  [`CONV_DATA_W/2];
  logic [`CONV_DATA_W+3:0]   quad    [2];
  logic [`CONV_DATA_W+3:0]   quad_q  [2];
  logic [`CONV_PROD_W-1:0]   mag;
  logic [3:1]                vld_q, sgn_q, fst_q;  // Flags per stage

  ////////////////////
  // Stage 1 partial products
  assign a_mag = feat[`CONV_DATA_W-1] ? -feat : feat;  // -128 maps to 128
  assign b_mag = wgt[`CONV_DATA_W-1]  ? -wgt  : wgt;

  always_comb begin
    for (int i = 0; i < `CONV_DATA_W; i++)
      pp[i] = b_mag[i] ? a_mag : '0;
  end

  ////////////////////
  // Stages 2 and 3, pairs then fours
  always_comb begin
    for (int j = 0; j < `CONV_DATA_W/2; j++)
      pair[j] = {2'b00, pp_q[2*j]} + {1'b0, pp_q[2*j+1], 1'b0};
    for (int k = 0; k < 2; k++)
      quad[k] = {2'b00, pair_q[2*k]} + {pair_q[2*k+1], 2'b00};
  end

  // Stage 4 final sum, upper half weighs 16
  assign mag = {4'h0, quad_q[0]} + {quad_q[1], 4'h0};

  always_ff @(posedge clk) begin
    pp_q     <= pp;
    pair_q   <= pair;
    quad_q   <= quad;
    sgn_q    <= {sgn_q[2:1], feat[`CONV_DATA_W-1] ^ wgt[`CONV_DATA_W-1]};
    fst_q    <= {fst_q[2:1], first};
    prod.prod  <= sgn_q[3] ? -$signed(mag) : $signed(mag);
    prod.first <= fst_q[3];
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_q      <= '0;
      prod_valid <= 1'b0;
    end else begin
      vld_q      <= {vld_q[2:1], in_fire};
      prod_valid <= vld_q[3];
    end
  end

endmodule

// ==== src/tap_counter.sv ====
////////////////////
// Tap index within a window and drain timer for the multiplier
////////////////////
`timescale 1ns/10ps
`include "conv_params.svh"

module tap_counter (
  input  logic       clk,
  input  logic       rstn,
  input  logic       tap_fire,
  input  logic       drain_start,
  output logic [3:0] tap_idx,
  output logic       last_tap,
  output logic       drain_done
);

  logic [3:0] drain_cnt;
  logic       drain_act;

  assign last_tap   = (tap_idx == 4'(`CONV_TAPS - 1));
  assign drain_done = drain_act && (drain_cnt == '0);

  always_ff @(posedge clk) begin
    if (!rstn)
      tap_idx <= '0;
    else if (tap_fire)
      tap_idx <= last_tap ? '0 : tap_idx + 4'd1;  // Wrap after ninth tap
  end

  // Multiplier depth plus the accumulator cycle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      drain_act <= 1'b0;
      drain_cnt <= '0;
    end else if (drain_start) begin
      drain_act <= 1'b1;
      drain_cnt <= 4'(`CONV_MULT_LAT + 1);
    end else if (drain_done) begin
      drain_act <= 1'b0;
    end else if (drain_act) begin
      drain_cnt <= drain_cnt - 4'd1;
    end
  end

  // No tap enters while the multiplier drains
  a_idx_range: assert property (@(posedge clk) disable iff (!rstn)
    tap_fire |-> !drain_act && (tap_idx <= 4'(`CONV_TAPS - 1)));

endmodule

// ==== tb.f ====
+incdir+include
src/conv_pkg.sv
src/sign_mag_mult.sv
src/mac_accum.sv
src/tap_counter.sv
src/conv_ctrl.sv
src/conv_top.sv
verif/tb_clk_gen.sv
verif/tb_conv.sv

// ==== verif/tb_clk_gen.sv ====
////////////////////
// Testbench clock and reset, 40 ns period, reset low for 16 cycles
////////////////////
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic rstn
);

  localparam int RST_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // Release on a falling edge
  initial begin
    rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

// ==== verif/tb_conv.sv ====
////////////////////
// Testbench for the convolution MAC unit
// Sends windows of taps and bias beats, checks each output transfer against a model
////////////////////
`timescale 1ns/10ps
`include "conv_params.svh"

module tb_conv import conv_pkg::*; ();

  localparam int N_WIN     = 21;
  localparam int MAX_GAP   = 3;  // Idle cycles before a tap
  localparam int MAX_STALL = 6;  // Longest low period of out_ready
  localparam int LIMIT     = 16 + 200
    + N_WIN * (`CONV_TAPS * (MAX_GAP + 1) + `CONV_MULT_LAT + MAX_STALL + 8);

  typedef logic signed [`CONV_DATA_W-1:0] data_t;

  logic       clk, rstn;
  logic       in_valid, in_ready, out_valid, out_ready;
  conv_beat_t in_beat;
  conv_acc_t  out_sum;

  data_t                            win_f [`CONV_TAPS];
  data_t                            win_w [`CONV_TAPS];
  logic signed [2*`CONV_DATA_W-1:0] cur_bias;  // Model of the bias register
  conv_acc_t                        exp_q [$];
  logic                             stall_on;
  int                               cyc, n_checks, n_out, val_err, other_err;
  int                               taps_seen, tap9_cyc, lat;
  logic                             ov_q, rdy_q;
  conv_acc_t                        sum_q;

  tb_clk_gen i_clk (.clk(clk), .rstn(rstn));

  conv_top i_dut (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_sum   (out_sum)
  );

  ////////////////////
  // Model and helpers

  // Bias plus the nine signed products of the current window
  function automatic conv_acc_t ref_sum(input logic signed [15:0] bias);
    int acc;
    acc = int'(bias);
    for (int i = 0; i < `CONV_TAPS; i++)
      acc = acc + int'(win_f[i]) * int'(win_w[i]);
    return conv_acc_t'(acc);
  endfunction

  task automatic check_val(input string name, input logic signed [63:0] got,
                           input logic signed [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      val_err++;
      $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_beat(input conv_op_e op, input data_t hi, input data_t lo,
                           input int gap);
    logic taken;
    in_valid = 1'b0;
    repeat (gap) @(negedge clk);
    in_beat.op   = op;
    in_beat.feat = hi;
    in_beat.wgt  = lo;
    in_valid     = 1'b1;
    do begin
      taken = in_ready;  // in_ready only moves on rising edges
      @(negedge clk);
    end while (!taken);
    in_valid = 1'b0;
  endtask

  task automatic load_bias(input logic signed [15:0] b);
    send_beat(OP_BIAS, b[15:8], b[7:0], 0);
    cur_bias = b;
  endtask

  task automatic fill_random();
    for (int i = 0; i < `CONV_TAPS; i++) begin
      win_f[i] = data_t'($urandom);
      win_w[i] = data_t'($urandom);
    end
  endtask

  task automatic fill_const(input data_t f, input data_t w);
    for (int i = 0; i < `CONV_TAPS; i++) begin
      win_f[i] = f;
      win_w[i] = w;
    end
  endtask

  task automatic run_window(input int max_gap);
    exp_q.push_back(ref_sum(cur_bias));
    for (int i = 0; i < `CONV_TAPS; i++)
      send_beat(OP_TAP, win_f[i], win_w[i], (max_gap > 0) ? $urandom_range(0, max_gap) : 0);
  endtask

  task automatic report_and_finish();
    $display("Checks %0d, value errors %0d, other errors %0d, results %0d of %0d",
             n_checks, val_err, other_err, n_out, N_WIN);
    if (val_err == 0 && other_err == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  endtask

  ////////////////////
  // Stimulus
  initial begin
    void'($urandom(92));
    in_valid = 1'b0;
    in_beat  = '0;
    stall_on = 1'b0;
    cur_bias = '0;
    @(posedge rstn);
    check_val("in_ready", 64'(in_ready), 64'(0));
    check_val("out_valid", 64'(out_valid), 64'(0));
    @(negedge clk);
    check_val("in_ready", 64'(in_ready), 64'(1));

    fill_random();  // No bias loaded yet
    run_window(0);

    load_bias(16'sd1000);
    repeat (3) begin
      fill_random();
      run_window(0);
    end
    load_bias(-16'sd517);
    repeat (2) begin
      fill_random();
      run_window(0);
    end

    // Largest magnitudes and zero taps
    load_bias(16'sh7fff);
    fill_const(8'sh80, 8'sh80);
    run_window(0);
    load_bias(16'sh8000);
    fill_const(8'sh80, 8'sh7f);
    run_window(0);
    load_bias(16'sh1234);
    fill_const(8'sh00, 8'sh00);
    run_window(0);

    repeat (6) begin
      fill_random();
      run_window(MAX_GAP);
    end

    stall_on = 1'b1;  // Back-pressure from here on
    repeat (6) begin
      if ($urandom_range(0, 2) == 0)
        load_bias(16'($urandom));
      fill_random();
      run_window(MAX_GAP);
    end

    while (exp_q.size() != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
    if (n_out != N_WIN) begin
      other_err++;
      $display("Error: %0d results seen for %0d windows", n_out, N_WIN);
    end
    report_and_finish();
  end

  // Output ready with bounded low periods
  initial begin
    out_ready = 1'b1;
    forever begin
      @(negedge clk);
      if (stall_on && $urandom_range(0, 2) == 0) begin
        out_ready = 1'b0;
        repeat ($urandom_range(1, MAX_STALL)) @(negedge clk);
        out_ready = 1'b1;
      end
    end
  end

  ////////////////////
  // Compare, cycle count and timeout
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!rstn) begin
      ov_q      = 1'b0;
      rdy_q     = 1'b1;
      taps_seen = 0;
    end else begin
      if (in_valid && in_ready && in_beat.op == OP_TAP) begin
        taps_seen++;
        if (taps_seen == `CONV_TAPS) begin
          taps_seen = 0;
          tap9_cyc  = cyc;
        end
      end
      if (out_valid && !ov_q)
        lat = cyc - 1 - tap9_cyc;  // out_valid rose at the previous edge
      if (ov_q && !rdy_q) begin
        if (!out_valid) begin
          other_err++;
          $display("Error at %0t: out_valid dropped before its transfer", $time);
        end else
          check_val("out_sum (held)", 64'(out_sum), 64'(sum_q));
      end
      if (out_valid && out_ready) begin
        n_out++;
        if (exp_q.size() == 0) begin
          other_err++;
          $display("Error at %0t: output transfer with no window pending", $time);
        end else
          check_val("out_sum", 64'(out_sum), 64'(exp_q.pop_front()));
        if (!ov_q)  // Ready was high from the first valid cycle
          check_val("out_valid latency", 64'(lat), 64'(`CONV_MULT_LAT + 2));
      end
      ov_q  = out_valid;
      rdy_q = out_ready;
      sum_q = out_sum;
    end
    if (cyc > LIMIT) begin
      other_err++;
      $display("Timeout after %0d cycles, %0d results outstanding", cyc, exp_q.size());
      report_and_finish();
    end
  end

endmodule
